//--- rvCfg_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath and instruction widths
`define RV_XLEN 64
`define RV_ILEN 32

// storage sizes
`define RV_REG_COUNT 32
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

// host bus widths
`define RV_APB_AW 8
`define RV_APB_DW 32

// host register offsets
`define RV_REG_CTRL 8'h00
`define RV_REG_STATUS 8'h04
`define RV_REG_IMEM_ADDR 8'h08
`define RV_REG_IMEM_DATA 8'h0C
`define RV_REG_DBGSEL 8'h10
`define RV_REG_DBGLO 8'h14
`define RV_REG_DBGHI 8'h18

`endif

//--- rvPkg.sv
`include "rvCfg_cfg.svh"

package rvPkg;

	// plain vectors with a meaning
	typedef logic [`RV_XLEN-1:0] xlenWord_t;
	typedef logic [`RV_ILEN-1:0] instrWord_t;
	typedef logic [$clog2(`RV_REG_COUNT)-1:0] regIdx_t;
	typedef logic [$clog2(`RV_IMEM_WORDS)-1:0] imemAddr_t;
	typedef logic [$clog2(`RV_DMEM_WORDS)-1:0] dmemAddr_t;
	typedef logic [`RV_APB_AW-1:0] apbAddr_t;
	typedef logic [`RV_APB_DW-1:0] apbData_t;

	// major opcodes of the kept subset
	typedef enum logic [6:0] {
		OPC_REG    = 7'b0110011,
		OPC_IMM    = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOp_t;

	typedef enum logic [2:0] {
		ST_IDLE, ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK, ST_HALT
	} ctrlState_t;

	typedef enum logic {SRCA_PC, SRCA_REG} opSrcA_t;
	typedef enum logic [1:0] {SRCB_REG, SRCB_FOUR, SRCB_IMM} opSrcB_t;
	typedef enum logic {WB_ALU, WB_MEM} wbSel_t;

	// control word from the FSM to the datapath
	typedef struct packed {
		logic pcWrite;
		logic branchEq;
		logic branchNe;
		logic irLoad;
		logic operandLoad;
		logic regWrite;
		logic memWrite;
		logic mdrLoad;
		opSrcA_t srcA;
		opSrcB_t srcB;
		aluOp_t aluOp;
		wbSel_t wbSel;
	} ctrlBus_t;

	// host side of the APB port
	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		apbAddr_t addr;
		apbData_t wdata;
	} apbReq_t;

	typedef struct packed {
		apbData_t rdata;
		logic ready;
	} apbRsp_t;

endpackage

//--- rvAlu.sv
`timescale 1ns/1ps

module rvAlu (
	input rvPkg::xlenWord_t a,
	input rvPkg::xlenWord_t b,
	input rvPkg::aluOp_t op,
	output rvPkg::xlenWord_t result
);
	import rvPkg::*;

	xlenWord_t sum;
	xlenWord_t diff;
	logic lessSigned;

	// shared adder and subtractor
	assign sum = a + b;
	assign diff = a - b;

	// slt compares as two's complement
	assign lessSigned = $signed(a) < $signed(b);

	always_comb
	begin
		case (op)
			ALU_ADD:
			begin
				result = sum;
			end
			ALU_SUB:
			begin
				result = diff;
			end
			ALU_AND:
			begin
				result = a & b;
			end
			ALU_OR:
			begin
				result = a | b;
			end
			ALU_SLT:
			begin
				// only bit zero carries the flag
				result = {{($bits(xlenWord_t)-1){1'b0}}, lessSigned};
			end
			default:
			begin
				result = '0;
			end
		endcase
	end

endmodule

//--- rvRegFile.sv
`timescale 1ns/1ps
`include "rvCfg_cfg.svh"

module rvRegFile (
	input logic clock,
	input logic reset,
	input rvPkg::regIdx_t readIdxA,
	input rvPkg::regIdx_t readIdxB,
	input rvPkg::regIdx_t dbgIdx,
	input rvPkg::regIdx_t writeIdx,
	input rvPkg::xlenWord_t writeData,
	input logic writeEnable,
	output rvPkg::xlenWord_t readDataA,
	output rvPkg::xlenWord_t readDataB,
	output rvPkg::xlenWord_t dbgData
);
	import rvPkg::*;

	// x0 has no storage
	xlenWord_t regs [1:`RV_REG_COUNT-1];

	// x0 reads as zero on every port
	function automatic xlenWord_t readReg(input regIdx_t idx);
		if (idx == '0)
			return '0;
		return regs[idx];
	endfunction

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 1; i < `RV_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeIdx != '0)
		begin
			// writes to x0 are dropped
			regs[writeIdx] <= writeData;
		end
	end

	// two core read ports and one host port
	always_comb
	begin
		readDataA = readReg(readIdxA);
		readDataB = readReg(readIdxB);
		dbgData = readReg(dbgIdx);
	end

endmodule

//--- rvMemory.sv
`timescale 1ns/1ps
`include "rvCfg_cfg.svh"

module rvMemory #(
	parameter int words = `RV_DMEM_WORDS,
	parameter int width = `RV_XLEN
) (
	input logic clock,
	input logic writeEnable,
	input logic [$clog2(words)-1:0] writeAddr,
	input logic [$clog2(words)-1:0] readAddr,
	input logic [width-1:0] writeData,
	output logic [width-1:0] readData
);

	// one entry per word
	logic [width-1:0] mem [words];

	// synchronous write port
	always_ff @(posedge clock)
	begin
		if (writeEnable)
			mem[writeAddr] <= writeData;
	end

	// read answers in the same cycle
	assign readData = mem[readAddr];

endmodule

//--- rvControl.sv
`timescale 1ns/1ps

module rvControl (
	input logic clock,
	input logic reset,
	input logic start,
	input rvPkg::instrWord_t instr,
	output rvPkg::ctrlBus_t ctrl,
	output logic busy,
	output logic halted
);
	import rvPkg::*;

	ctrlState_t state;
	ctrlState_t nextState;
	opcode_t opcode;
	logic [2:0] funct3;
	aluOp_t regAluOp;

	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];

	// R-type operation from funct3 and funct7 bit 5
	always_comb
	begin
		case (funct3)
			3'b000:
				regAluOp = instr[30] ? ALU_SUB : ALU_ADD;
			3'b010:
				regAluOp = ALU_SLT;
			3'b110:
				regAluOp = ALU_OR;
			3'b111:
				regAluOp = ALU_AND;
			default:
				regAluOp = ALU_ADD;
		endcase
	end

	// next state
	always_comb
	begin
		nextState = state;
		case (state)
			ST_IDLE, ST_HALT:
				if (start)
					nextState = ST_FETCH;
			ST_FETCH:
				nextState = ST_DECODE;
			ST_DECODE:
				nextState = ST_EXECUTE;
			ST_EXECUTE:
			begin
				case (opcode)
					OPC_REG, OPC_IMM:
						nextState = ST_WRITEBACK;
					OPC_LOAD, OPC_STORE:
						nextState = ST_MEMORY;
					OPC_BRANCH:
						nextState = ST_FETCH;
					// ebreak and any unknown opcode stop the core
					OPC_SYSTEM:
						nextState = ST_HALT;
					default:
						nextState = ST_HALT;
				endcase
			end
			ST_MEMORY:
				nextState = (opcode == OPC_LOAD) ? ST_WRITEBACK : ST_FETCH;
			ST_WRITEBACK:
				nextState = ST_FETCH;
			default:
				nextState = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= nextState;
	end

	// control word per state
	always_comb
	begin
		ctrl = '0;
		ctrl.srcA = SRCA_REG;
		ctrl.srcB = SRCB_REG;
		ctrl.aluOp = ALU_ADD;
		ctrl.wbSel = WB_ALU;
		case (state)
			ST_FETCH:
			begin
				// ir gets the word, pc moves on by four
				ctrl.irLoad = 1'b1;
				ctrl.pcWrite = 1'b1;
				ctrl.srcA = SRCA_PC;
				ctrl.srcB = SRCB_FOUR;
			end
			ST_DECODE:
				ctrl.operandLoad = 1'b1;
			ST_EXECUTE:
			begin
				case (opcode)
					OPC_REG:
						ctrl.aluOp = regAluOp;
					OPC_IMM, OPC_LOAD, OPC_STORE:
						ctrl.srcB = SRCB_IMM;
					OPC_BRANCH:
					begin
						// target from pc of the branch, datapath tests the condition
						ctrl.srcA = SRCA_PC;
						ctrl.srcB = SRCB_IMM;
						ctrl.branchEq = (funct3 == 3'b000);
						ctrl.branchNe = (funct3 == 3'b001);
					end
					default:
						ctrl.aluOp = ALU_ADD;
				endcase
			end
			ST_MEMORY:
			begin
				ctrl.mdrLoad = (opcode == OPC_LOAD);
				ctrl.memWrite = (opcode == OPC_STORE);
			end
			ST_WRITEBACK:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = (opcode == OPC_LOAD) ? WB_MEM : WB_ALU;
			end
			default:
				ctrl.aluOp = ALU_ADD;
		endcase
	end

	// status levels for the host
	assign busy = !(state inside {ST_IDLE, ST_HALT});
	assign halted = (state == ST_HALT);

endmodule

//--- rvDatapath.sv
`timescale 1ns/1ps

module rvDatapath (
	input logic clock,
	input logic reset,
	input logic start,
	input rvPkg::ctrlBus_t ctrl,
	input rvPkg::instrWord_t imemData,
	output rvPkg::imemAddr_t imemAddr,
	output rvPkg::instrWord_t instr,
	output rvPkg::regIdx_t regIdxA,
	output rvPkg::regIdx_t regIdxB,
	output rvPkg::regIdx_t regWriteIdx,
	input rvPkg::xlenWord_t regDataA,
	input rvPkg::xlenWord_t regDataB,
	output rvPkg::xlenWord_t regWriteData,
	output logic regWrite,
	output rvPkg::dmemAddr_t dmemAddr,
	output rvPkg::xlenWord_t dmemWriteData,
	output logic dmemWrite,
	input rvPkg::xlenWord_t dmemReadData
);
	import rvPkg::*;

	localparam int immPad = $bits(xlenWord_t) - 12;

	xlenWord_t pc;
	xlenWord_t instrPc;
	instrWord_t ir;
	xlenWord_t regA;
	xlenWord_t regB;
	xlenWord_t aluOut;
	xlenWord_t mdr;
	xlenWord_t imm;
	xlenWord_t aluA;
	xlenWord_t aluB;
	xlenWord_t aluResult;
	logic branchTaken;

	// pc, ir and the pc of the instruction in ir
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			pc <= '0;
			instrPc <= '0;
			ir <= '0;
		end
		else
		begin
			// a start always runs from address zero
			if (start)
				pc <= '0;
			else if (ctrl.pcWrite || branchTaken)
				pc <= aluResult;
			if (ctrl.irLoad)
			begin
				ir <= imemData;
				instrPc <= pc;
			end
		end
	end

	// operand, alu result and memory data registers
	always_ff @(posedge clock)
	begin
		if (ctrl.operandLoad)
		begin
			regA <= regDataA;
			regB <= regDataB;
		end
		// alu result is captured every cycle
		aluOut <= aluResult;
		if (ctrl.mdrLoad)
			mdr <= dmemReadData;
	end

	// sign extension by instruction format
	always_comb
	begin
		case (opcode_t'(ir[6:0]))
			OPC_STORE:
				imm = {{immPad{ir[31]}}, ir[31:25], ir[11:7]};
			OPC_BRANCH:
				imm = {{(immPad-1){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			default:
				imm = {{immPad{ir[31]}}, ir[31:20]};
		endcase
	end

	// fetch reads the live pc, later states use the pc of the held instruction
	assign aluA = (ctrl.srcA == SRCA_PC) ? (ctrl.irLoad ? pc : instrPc) : regA;

	always_comb
	begin
		case (ctrl.srcB)
			SRCB_REG:
				aluB = regB;
			SRCB_FOUR:
				aluB = xlenWord_t'(4);
			SRCB_IMM:
				aluB = imm;
			default:
				aluB = '0;
		endcase
	end

	rvAlu alu (
		.a(aluA),
		.b(aluB),
		.op(ctrl.aluOp),
		.result(aluResult)
	);

	// branch condition from the operand registers
	assign branchTaken = (ctrl.branchEq && regA == regB) || (ctrl.branchNe && regA != regB);

	// instruction fetch, word index from the byte pc
	assign imemAddr = pc[2 +: $bits(imemAddr_t)];
	assign instr = ir;

	// register file fields
	assign regIdxA = ir[19:15];
	assign regIdxB = ir[24:20];
	assign regWriteIdx = ir[11:7];
	assign regWriteData = (ctrl.wbSel == WB_MEM) ? mdr : aluOut;
	assign regWrite = ctrl.regWrite;

	// doubleword index from the computed address
	assign dmemAddr = aluOut[3 +: $bits(dmemAddr_t)];
	assign dmemWriteData = regB;
	assign dmemWrite = ctrl.memWrite;

endmodule

//--- rvApbConfig.sv
`timescale 1ns/1ps
`include "rvCfg_cfg.svh"

module rvApbConfig (
	input logic clock,
	input logic reset,
	input rvPkg::apbReq_t apbReq,
	output rvPkg::apbRsp_t apbRsp,
	input logic busy,
	input logic halted,
	output logic start,
	output logic imemWrite,
	output rvPkg::imemAddr_t imemWriteAddr,
	output rvPkg::instrWord_t imemWriteData,
	output rvPkg::regIdx_t dbgIdx,
	input rvPkg::xlenWord_t dbgData
);
	import rvPkg::*;

	logic access;
	logic writeAccess;
	imemAddr_t loadPtr;
	regIdx_t dbgSel;

	// access phase of a transfer
	assign access = apbReq.sel && apbReq.enable;
	assign writeAccess = access && apbReq.write;

	// program store, blocked while the core runs
	assign imemWrite = writeAccess && apbReq.addr == `RV_REG_IMEM_DATA && !busy;
	assign imemWriteAddr = loadPtr;
	assign imemWriteData = apbReq.wdata;
	assign dbgIdx = dbgSel;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			start <= 1'b0;
			loadPtr <= '0;
			dbgSel <= '0;
		end
		else
		begin
			// start is a single cycle pulse
			start <= writeAccess && apbReq.addr == `RV_REG_CTRL && apbReq.wdata[0] && !busy;
			if (writeAccess && apbReq.addr == `RV_REG_IMEM_ADDR)
				loadPtr <= apbReq.wdata[$bits(imemAddr_t)-1:0];
			else if (imemWrite)
				loadPtr <= loadPtr + 1'b1;
			if (writeAccess && apbReq.addr == `RV_REG_DBGSEL)
				dbgSel <= apbReq.wdata[$bits(regIdx_t)-1:0];
		end
	end

	// read mux, no wait states
	always_comb
	begin
		apbRsp.ready = 1'b1;
		case (apbReq.addr)
			`RV_REG_STATUS:
				apbRsp.rdata = {{($bits(apbData_t)-2){1'b0}}, halted, busy};
			`RV_REG_IMEM_ADDR:
				apbRsp.rdata = apbData_t'(loadPtr);
			`RV_REG_DBGSEL:
				apbRsp.rdata = apbData_t'(dbgSel);
			`RV_REG_DBGLO:
				apbRsp.rdata = dbgData[31:0];
			`RV_REG_DBGHI:
				apbRsp.rdata = dbgData[63:32];
			// ctrl reads back as zero
			default:
				apbRsp.rdata = '0;
		endcase
	end

endmodule

//--- rvTop.sv
`timescale 1ns/1ps
`include "rvCfg_cfg.svh"

module rvTop (
	input logic clock,
	input logic reset,
	input rvPkg::apbReq_t apbReq,
	output rvPkg::apbRsp_t apbRsp
);
	import rvPkg::*;

	// host side
	logic start;
	logic busy;
	logic halted;
	logic imemWrite;
	imemAddr_t imemWriteAddr;
	instrWord_t imemWriteData;
	regIdx_t dbgIdx;
	xlenWord_t dbgData;

	// core side
	ctrlBus_t ctrl;
	instrWord_t instr;
	instrWord_t imemData;
	imemAddr_t imemAddr;
	regIdx_t regIdxA;
	regIdx_t regIdxB;
	regIdx_t regWriteIdx;
	xlenWord_t regDataA;
	xlenWord_t regDataB;
	xlenWord_t regWriteData;
	logic regWrite;
	dmemAddr_t dmemAddr;
	xlenWord_t dmemWriteData;
	xlenWord_t dmemReadData;
	logic dmemWrite;

	rvApbConfig config0 (
		.clock(clock),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.busy(busy),
		.halted(halted),
		.start(start),
		.imemWrite(imemWrite),
		.imemWriteAddr(imemWriteAddr),
		.imemWriteData(imemWriteData),
		.dbgIdx(dbgIdx),
		.dbgData(dbgData)
	);

	rvControl control (
		.clock(clock),
		.reset(reset),
		.start(start),
		.instr(instr),
		.ctrl(ctrl),
		.busy(busy),
		.halted(halted)
	);

	rvDatapath datapath (
		.clock(clock),
		.reset(reset),
		.start(start),
		.ctrl(ctrl),
		.imemData(imemData),
		.imemAddr(imemAddr),
		.instr(instr),
		.regIdxA(regIdxA),
		.regIdxB(regIdxB),
		.regWriteIdx(regWriteIdx),
		.regDataA(regDataA),
		.regDataB(regDataB),
		.regWriteData(regWriteData),
		.regWrite(regWrite),
		.dmemAddr(dmemAddr),
		.dmemWriteData(dmemWriteData),
		.dmemWrite(dmemWrite),
		.dmemReadData(dmemReadData)
	);

	rvRegFile regFile (
		.clock(clock),
		.reset(reset),
		.readIdxA(regIdxA),
		.readIdxB(regIdxB),
		.dbgIdx(dbgIdx),
		.writeIdx(regWriteIdx),
		.writeData(regWriteData),
		.writeEnable(regWrite),
		.readDataA(regDataA),
		.readDataB(regDataB),
		.dbgData(dbgData)
	);

	// program store, filled over APB
	rvMemory #(.words(`RV_IMEM_WORDS), .width(`RV_ILEN)) imem (
		.clock(clock),
		.writeEnable(imemWrite),
		.writeAddr(imemWriteAddr),
		.readAddr(imemAddr),
		.writeData(imemWriteData),
		.readData(imemData)
	);

	// doubleword data store
	rvMemory #(.words(`RV_DMEM_WORDS), .width(`RV_XLEN)) dmem (
		.clock(clock),
		.writeEnable(dmemWrite),
		.writeAddr(dmemAddr),
		.readAddr(dmemAddr),
		.writeData(dmemWriteData),
		.readData(dmemReadData)
	);

endmodule

//--- tbRvTop.sv
`timescale 1ns/1ps
`include "rvCfg_cfg.svh"

module tbRvTop;
	import rvPkg::*;

	localparam int driveDelay = 1;
	localparam int numPrograms = 20;
	localparam int maxInstr = 30;
	localparam int loadXfers = 32;
	// DBG_SEL write plus two half reads per register
	localparam int readXfers = 96;
	localparam int margin = 40;
	localparam int perRun = maxInstr * 5 + loadXfers * 2 + readXfers * 2 + margin;
	// reset check, memory clear, random programs and one rerun
	localparam int cycleLimit = (numPrograms + 3) * perRun;

	// RV64I major opcodes
	localparam logic [6:0] opReg = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam instrWord_t ebreakWord = 32'h00100073;

	logic clock;
	logic reset;
	apbReq_t apbReq;
	apbRsp_t apbRsp;

	int errors;
	int checks;
	int cycles;

	// current program and the reference machine state
	instrWord_t prog [64];
	int progLen;
	logic [63:0] modelRegs [`RV_REG_COUNT];
	logic [63:0] modelMem [`RV_DMEM_WORDS];

	rvTop uut (
		.clock(clock),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp)
	);

	always #2 clock = ~clock;

	// watchdog on the total cycle count
	initial
	begin
		cycles = 0;
		while (cycles < cycleLimit)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", cycles);
		$display("Regression failed");
		$finish;
	end

	task automatic expectEqual(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// two-cycle APB write, entered just after a rising edge
	task automatic writeApb(input apbAddr_t addr, input apbData_t data);
		apbReq.sel = 1'b1;
		apbReq.enable = 1'b0;
		apbReq.write = 1'b1;
		apbReq.addr = addr;
		apbReq.wdata = data;
		@(posedge clock);
		#driveDelay;
		apbReq.enable = 1'b1;
		@(posedge clock);
		#driveDelay;
		apbReq = '0;
	endtask

	task automatic readApb(input apbAddr_t addr, output apbData_t data);
		logic ready;
		apbReq.sel = 1'b1;
		apbReq.enable = 1'b0;
		apbReq.write = 1'b0;
		apbReq.addr = addr;
		apbReq.wdata = '0;
		@(posedge clock);
		#driveDelay;
		apbReq.enable = 1'b1;
		// sample in the middle of the access phase
		@(negedge clock);
		data = apbRsp.rdata;
		ready = apbRsp.ready;
		@(posedge clock);
		#driveDelay;
		apbReq = '0;
		expectEqual("pready", 64'(ready), 64'd1);
	endtask

	// instruction encoders
	function automatic instrWord_t rType(input logic [6:0] funct7, input regIdx_t rs2,
		input regIdx_t rs1, input logic [2:0] funct3, input regIdx_t rd);
		return {funct7, rs2, rs1, funct3, rd, opReg};
	endfunction

	function automatic instrWord_t iType(input logic [11:0] imm, input regIdx_t rs1,
		input logic [2:0] funct3, input regIdx_t rd, input logic [6:0] opcode);
		return {imm, rs1, funct3, rd, opcode};
	endfunction

	function automatic instrWord_t sType(input logic [11:0] imm, input regIdx_t rs2,
		input regIdx_t rs1);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], opStore};
	endfunction

	function automatic instrWord_t bType(input logic [12:0] imm, input regIdx_t rs2,
		input regIdx_t rs1, input logic [2:0] funct3);
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opBranch};
	endfunction

	// low registers half the time so results feed later instructions
	function automatic regIdx_t pickReg();
		if ($urandom_range(0, 1) == 0)
			return regIdx_t'($urandom_range(0, 7));
		return regIdx_t'($urandom_range(0, 31));
	endfunction

	task automatic genProgram();
		logic [2:0] funct3Table [5];
		int body;
		int kind;
		int op;
		int target;
		regIdx_t rs1;
		regIdx_t rs2;
		// add, sub, and, or, slt
		funct3Table = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b010};
		body = $urandom_range(9, maxInstr - 1);
		for (int i = 0; i < body; i++)
		begin
			kind = $urandom_range(0, 9);
			// no branch in the first slots, the core stays busy for the host checks
			if (kind >= 8 && i < 4)
				kind = 4;
			rs1 = pickReg();
			rs2 = pickReg();
			case (kind)
				0, 1, 2, 3:
				begin
					op = $urandom_range(0, 4);
					prog[i] = rType((op == 1) ? 7'h20 : 7'h00, rs2, rs1, funct3Table[op], pickReg());
				end
				4, 5:
					prog[i] = iType(12'($urandom_range(0, 4095)), rs1, 3'b000, pickReg(), opImm);
				6:
					prog[i] = sType(12'($urandom_range(0, 31) * 8), rs2, 5'd0);
				7:
					prog[i] = iType(12'($urandom_range(0, 31) * 8), 5'd0, 3'b011, pickReg(), opLoad);
				default:
				begin
					// forward only, at most up to the ebreak
					if ($urandom_range(0, 3) == 0)
						rs2 = rs1;
					target = $urandom_range(i + 1, body);
					prog[i] = bType(13'((target - i) * 4), rs2, rs1, (kind == 8) ? 3'b000 : 3'b001);
				end
			endcase
		end
		prog[body] = ebreakWord;
		progLen = body + 1;
	endtask

	// stores x0 to every word the random programs touch
	task automatic clearProgram();
		for (int i = 0; i < 32; i++)
			prog[i] = sType(12'(i * 8), 5'd0, 5'd0);
		prog[32] = ebreakWord;
		progLen = 33;
	endtask

	// instruction-set interpreter, always from pc zero
	task automatic runModel();
		logic [63:0] pc;
		logic [63:0] nextPc;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] res;
		logic [63:0] addr;
		logic [63:0] immI;
		logic [63:0] immS;
		logic [63:0] immB;
		instrWord_t w;
		bit wr;
		bit done;
		int steps;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 64)
		begin
			w = prog[pc[7:2]];
			a = modelRegs[w[19:15]];
			b = modelRegs[w[24:20]];
			immI = {{52{w[31]}}, w[31:20]};
			immS = {{52{w[31]}}, w[31:25], w[11:7]};
			immB = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			addr = a + ((w[6:0] == opStore) ? immS : immI);
			nextPc = pc + 64'd4;
			res = '0;
			wr = 1'b0;
			case (w[6:0])
				opReg:
				begin
					wr = 1'b1;
					case (w[14:12])
						3'b000:
							res = w[30] ? a - b : a + b;
						3'b010:
							res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
						3'b110:
							res = a | b;
						3'b111:
							res = a & b;
						default:
							res = '0;
					endcase
				end
				opImm:
				begin
					wr = 1'b1;
					res = a + immI;
				end
				opLoad:
				begin
					wr = 1'b1;
					res = modelMem[addr[10:3]];
				end
				opStore:
					modelMem[addr[10:3]] = b;
				opBranch:
				begin
					// funct3 bit 0 picks bne over beq
					if ((!w[12] && a == b) || (w[12] && a != b))
						nextPc = pc + immB;
				end
				default:
					done = 1'b1;
			endcase
			// x0 stays zero
			if (wr && w[11:7] != 5'd0)
				modelRegs[w[11:7]] = res;
			pc = nextPc;
			steps++;
		end
	endtask

	task automatic compareRegs();
		apbData_t lo;
		apbData_t hi;
		for (int r = 0; r < `RV_REG_COUNT; r++)
		begin
			writeApb(`RV_REG_DBGSEL, apbData_t'(r));
			readApb(`RV_REG_DBGLO, lo);
			readApb(`RV_REG_DBGHI, hi);
			expectEqual($sformatf("register x%0d", r), {hi, lo}, modelRegs[r]);
		end
	endtask

	task automatic runProgram(input bit reload);
		apbData_t status;
		apbData_t ptr;
		if (reload)
		begin
			writeApb(`RV_REG_IMEM_ADDR, 32'd0);
			for (int k = 0; k < progLen; k++)
				writeApb(`RV_REG_IMEM_DATA, prog[k]);
		end
		writeApb(`RV_REG_CTRL, 32'd1);
		// halted clears and busy rises once the start is taken
		readApb(`RV_REG_STATUS, status);
		expectEqual("status after start", 64'(status), 64'd1);
		// both land while busy and are dropped
		writeApb(`RV_REG_CTRL, 32'd1);
		writeApb(`RV_REG_IMEM_DATA, 32'hFFFF_FFFF);
		readApb(`RV_REG_IMEM_ADDR, ptr);
		expectEqual("load pointer while busy", 64'(ptr), 64'(progLen));
		// poll until ebreak
		do
		begin
			readApb(`RV_REG_STATUS, status);
		end
		while (status[1] == 1'b0);
		expectEqual("status after halt", 64'(status), 64'd2);
		runModel();
		compareRegs();
	endtask

	initial
	begin
		apbData_t status;
		errors = 0;
		checks = 0;
		clock = 1'b0;
		reset = 1'b1;
		apbReq = '0;
		progLen = 0;
		for (int r = 0; r < `RV_REG_COUNT; r++)
			modelRegs[r] = '0;
		for (int m = 0; m < `RV_DMEM_WORDS; m++)
			modelMem[m] = '0;
		void'($urandom(6));
		repeat (3) @(posedge clock);
		#driveDelay;
		reset = 1'b0;

		// idle core and cleared registers
		readApb(`RV_REG_STATUS, status);
		expectEqual("status after reset", 64'(status), 64'd0);
		compareRegs();

		// data memory has no reset
		clearProgram();
		runProgram(1'b1);

		for (int p = 0; p < numPrograms; p++)
		begin
			genProgram();
			runProgram(1'b1);
		end

		// restart without reload, registers and memory carried over
		runProgram(1'b0);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- multiCycleRv.f
+incdir+.
rvPkg.sv
rvAlu.sv
rvRegFile.sv
rvMemory.sv
rvControl.sv
rvDatapath.sv
rvApbConfig.sv
rvTop.sv
tbRvTop.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbRvTop -f multiCycleRv.f -o simRv
./obj_dir/simRv > sim.log
cat sim.log

if grep -qx "Regression passed" sim.log; then
	exit 0
else
	exit 1
fi
